// ==== dcache_pkg.sv ====
package dcache_pkg;

    // fixed geometry, the set count comes from the SETS parameter
    localparam int line_words = 4;
    localparam int way_num = 4;

    typedef logic [31:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [line_words-1:0] line_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_e;

    // store data is taken from the low bits of wdata
    typedef struct packed {
        logic         store;
        logic [31:0]  addr;
        word_t        wdata;
        access_size_e size;
        logic         signed_ext;
        logic [2:0]   spare;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
    } cpu_rsp_t;

    // line-aligned refill address
    typedef struct packed {
        logic [31:0] addr;
    } mem_rd_req_t;

    // line-aligned write-back address
    typedef struct packed {
        logic [31:0] addr;
    } mem_wr_req_t;

    // one bit per way, at most one set
    typedef logic [way_num-1:0] way_mask_t;

endpackage

// ==== dcache_tag_array.sv ====
module dcache_tag_array #(
    parameter int SETS = 64
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [$clog2(SETS)-1:0] index,
    input  logic [27-$clog2(SETS):0] tag,
    input  dcache_pkg::way_mask_t way_we,
    input  logic                  set_dirty,
    input  logic                  clr_dirty,
    input  dcache_pkg::way_mask_t victim_way,
    output dcache_pkg::way_mask_t hit_way,
    output logic [27-$clog2(SETS):0] victim_tag,
    output logic                  victim_valid,
    output logic                  victim_dirty
);
    localparam int idx_w = $clog2(SETS);
    localparam int tag_w = 32 - idx_w - 4;

    logic [dcache_pkg::way_num-1:0][tag_w-1:0] tag_q [SETS];
    logic [SETS-1:0][dcache_pkg::way_num-1:0] valid_q;
    logic [SETS-1:0][dcache_pkg::way_num-1:0] dirty_q;

    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            if (way_we[w]) begin
                tag_q[index][w] <= tag;
            end
        end
    end

    // a way write always leaves the way valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            for (int w = 0; w < dcache_pkg::way_num; w++) begin
                if (way_we[w]) begin
                    valid_q[index][w] <= 1'b1;
                    if (set_dirty) begin
                        dirty_q[index][w] <= 1'b1;
                    end else if (clr_dirty) begin
                        dirty_q[index][w] <= 1'b0;
                    end
                end
            end
        end
    end

    // compare all ways at once, victim fields follow the one-hot select
    always_comb begin
        victim_tag = '0;
        victim_valid = 1'b0;
        victim_dirty = 1'b0;
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            hit_way[w] = valid_q[index][w] && (tag_q[index][w] == tag);
            if (victim_way[w]) begin
                victim_tag = tag_q[index][w];
                victim_valid = valid_q[index][w];
                victim_dirty = dirty_q[index][w];
            end
        end
    end

endmodule

// ==== dcache_data_array.sv ====
module dcache_data_array #(
    parameter int SETS = 64
) (
    input  logic                    clk,
    input  logic [$clog2(SETS)-1:0] index,
    input  logic [1:0]              word_sel,
    input  dcache_pkg::way_mask_t   way_we,
    input  logic [3:0]              byte_en,
    input  dcache_pkg::word_t       wdata,
    input  logic                    fill,
    input  dcache_pkg::line_t       fill_line,
    output dcache_pkg::line_t [dcache_pkg::way_num-1:0] set_lines
);
    dcache_pkg::line_t [dcache_pkg::way_num-1:0] mem_q [SETS];

    // fill replaces the whole line, otherwise one word under byte enables
    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            if (way_we[w]) begin
                if (fill) begin
                    mem_q[index][w] <= fill_line;
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (byte_en[b]) begin
                            mem_q[index][w][word_sel][b*8 +: 8] <= wdata[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

    // asynchronous read of the whole set
    assign set_lines = mem_q[index];

endmodule

// ==== dcache_plru.sv ====
module dcache_plru #(
    parameter int SETS = 64
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [$clog2(SETS)-1:0] index,
    input  logic                    touch,
    input  dcache_pkg::way_mask_t   touch_way,
    output dcache_pkg::way_mask_t   victim_way
);
    // bit 0 picks the half, bit 1 ways 0/1, bit 2 ways 2/3
    logic [SETS-1:0][2:0] tree_q;
    logic [1:0] touch_idx;
    logic [2:0] bits;

    assign touch_idx = {touch_way[3] | touch_way[2], touch_way[3] | touch_way[1]};
    assign bits = tree_q[index];

    always_comb begin
        victim_way = '0;
        if (!bits[0]) begin
            victim_way[{1'b0, bits[1]}] = 1'b1;
        end else begin
            victim_way[{1'b1, bits[2]}] = 1'b1;
        end
    end

    // point every node on the path away from the touched way
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tree_q <= '0;
        end else if (touch) begin
            tree_q[index][0] <= ~touch_idx[1];
            if (!touch_idx[1]) begin
                tree_q[index][1] <= ~touch_idx[0];
            end else begin
                tree_q[index][2] <= ~touch_idx[0];
            end
        end
    end

endmodule

// ==== dcache_load_align.sv ====
module dcache_load_align (
    input  dcache_pkg::line_t        line,
    input  logic [1:0]               word_sel,
    input  logic [1:0]               byte_off,
    input  dcache_pkg::access_size_e size,
    input  logic                     signed_ext,
    output dcache_pkg::word_t        rdata
);
    dcache_pkg::word_t word;
    dcache_pkg::word_t shifted;

    assign word = line[word_sel];

    // move the addressed field down to bit 0
    assign shifted = word >> {byte_off, 3'b000};

    always_comb begin
        unique case (size)
            dcache_pkg::size_byte: begin
                rdata = {{24{signed_ext & shifted[7]}}, shifted[7:0]};
            end
            dcache_pkg::size_half: begin
                rdata = {{16{signed_ext & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                rdata = shifted;
            end
        endcase
    end

endmodule

// ==== dcache_ctrl.sv ====
module dcache_ctrl #(
    parameter int SETS = 64
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cpu_req_valid,
    output logic                      cpu_req_ready,
    input  dcache_pkg::cpu_req_t      cpu_req,
    output logic                      cpu_rsp_valid,
    output dcache_pkg::cpu_req_t      req_buf,
    output logic                      mem_rd_valid,
    input  logic                      mem_rd_ready,
    output dcache_pkg::mem_rd_req_t   mem_rd_req,
    input  logic                      mem_rd_data_valid,
    input  dcache_pkg::word_t         mem_rd_data,
    input  logic                      mem_rd_last,
    output logic                      mem_wr_valid,
    input  logic                      mem_wr_ready,
    output dcache_pkg::mem_wr_req_t   mem_wr_req,
    output logic                      mem_wr_data_valid,
    input  logic                      mem_wr_data_ready,
    output dcache_pkg::word_t         mem_wr_data,
    output logic                      mem_wr_last,
    output logic                      mem_wr_resp_ready,
    input  logic                      mem_wr_resp_valid,
    output logic [$clog2(SETS)-1:0]   index,
    output logic [27-$clog2(SETS):0]  tag,
    output logic [1:0]                word_sel,
    output logic [3:0]                byte_en,
    output dcache_pkg::word_t         wdata,
    output dcache_pkg::way_mask_t     tag_way_we,
    output logic                      set_dirty,
    output logic                      clr_dirty,
    output dcache_pkg::way_mask_t     data_way_we,
    output logic                      fill,
    output dcache_pkg::line_t         fill_line,
    output logic                      touch,
    output dcache_pkg::way_mask_t     touch_way,
    input  dcache_pkg::way_mask_t     hit_way,
    input  dcache_pkg::way_mask_t     victim_way,
    input  logic [27-$clog2(SETS):0]  victim_tag,
    input  logic                      victim_valid,
    input  logic                      victim_dirty,
    input  dcache_pkg::line_t         wb_line
);
    localparam int idx_w = $clog2(SETS);
    localparam int tag_w = 32 - idx_w - 4;

    typedef enum logic [3:0] {
        st_idle,
        st_lookup,
        st_wb_addr,
        st_wb_data,
        st_wb_resp,
        st_rd_req,
        st_rd_data,
        st_install,
        st_respond
    } state_e;

    state_e state_q, state_d;
    dcache_pkg::cpu_req_t req_q;
    dcache_pkg::way_mask_t mb_way_q;
    logic [tag_w-1:0] mb_tag_q;
    dcache_pkg::line_t mb_line_q;
    dcache_pkg::line_t fill_q;
    logic [1:0] beat_q;
    logic hit;

    assign hit = |hit_way;
    assign req_buf = req_q;
    assign index = req_q.addr[idx_w+3:4];
    assign tag = req_q.addr[31:idx_w+4];
    assign word_sel = req_q.addr[3:2];

    // store data moves into its byte lane
    assign wdata = req_q.wdata << {req_q.addr[1:0], 3'b000};

    always_comb begin
        unique case (req_q.size)
            dcache_pkg::size_byte: byte_en = 4'b0001 << req_q.addr[1:0];
            dcache_pkg::size_half: byte_en = 4'b0011 << req_q.addr[1:0];
            default: byte_en = 4'b1111;
        endcase
    end

    // store miss merges into the refilled line
    always_comb begin
        fill_line = fill_q;
        for (int b = 0; b < 4; b++) begin
            if (req_q.store && byte_en[b]) begin
                fill_line[word_sel][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    assign mem_rd_req.addr = {req_q.addr[31:4], 4'b0000};
    assign mem_wr_req.addr = {mb_tag_q, index, 4'b0000};
    assign mem_wr_data = mb_line_q[beat_q];
    assign mem_wr_last = (beat_q == 2'd3);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            beat_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == st_wb_addr || state_q == st_rd_req) begin
                beat_q <= '0;
            end else if ((state_q == st_wb_data && mem_wr_data_ready) ||
                         (state_q == st_rd_data && mem_rd_data_valid)) begin
                beat_q <= beat_q + 2'd1;
            end
        end
    end

    // request, miss and refill buffers
    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_req_ready) begin
            req_q <= cpu_req;
        end
        if (state_q == st_lookup && !hit) begin
            mb_way_q <= victim_way;
            mb_tag_q <= victim_tag;
            mb_line_q <= wb_line;
        end
        if (state_q == st_rd_data && mem_rd_data_valid) begin
            fill_q[beat_q] <= mem_rd_data;
        end
    end

    always_comb begin
        state_d = state_q;
        cpu_req_ready = 1'b0;
        cpu_rsp_valid = 1'b0;
        mem_rd_valid = 1'b0;
        mem_wr_valid = 1'b0;
        mem_wr_data_valid = 1'b0;
        mem_wr_resp_ready = 1'b0;
        tag_way_we = '0;
        data_way_we = '0;
        set_dirty = 1'b0;
        clr_dirty = 1'b0;
        fill = 1'b0;
        touch = 1'b0;
        touch_way = hit_way;
        unique case (state_q)
            st_idle: begin
                cpu_req_ready = 1'b1;
                if (cpu_req_valid) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                if (hit) begin
                    // store hit writes the word and marks the line dirty
                    cpu_rsp_valid = 1'b1;
                    touch = 1'b1;
                    if (req_q.store) begin
                        tag_way_we = hit_way;
                        data_way_we = hit_way;
                        set_dirty = 1'b1;
                    end
                    state_d = st_idle;
                end else if (victim_valid && victim_dirty) begin
                    state_d = st_wb_addr;
                end else begin
                    state_d = st_rd_req;
                end
            end
            st_wb_addr: begin
                mem_wr_valid = 1'b1;
                if (mem_wr_ready) begin
                    state_d = st_wb_data;
                end
            end
            st_wb_data: begin
                mem_wr_data_valid = 1'b1;
                if (mem_wr_data_ready && mem_wr_last) begin
                    state_d = st_wb_resp;
                end
            end
            st_wb_resp: begin
                mem_wr_resp_ready = 1'b1;
                if (mem_wr_resp_valid) begin
                    state_d = st_rd_req;
                end
            end
            st_rd_req: begin
                mem_rd_valid = 1'b1;
                if (mem_rd_ready) begin
                    state_d = st_rd_data;
                end
            end
            st_rd_data: begin
                if (mem_rd_data_valid && mem_rd_last) begin
                    state_d = st_install;
                end
            end
            st_install: begin
                fill = 1'b1;
                tag_way_we = mb_way_q;
                data_way_we = mb_way_q;
                set_dirty = req_q.store;
                clr_dirty = !req_q.store;
                touch = 1'b1;
                touch_way = mb_way_q;
                state_d = st_respond;
            end
            st_respond: begin
                // tag now matches, so the load reads the new line as a hit
                cpu_rsp_valid = 1'b1;
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

endmodule

// ==== dcache.sv ====
module dcache #(
    parameter int SETS = 64
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cpu_req_valid,
    output logic                    cpu_req_ready,
    input  dcache_pkg::cpu_req_t    cpu_req,
    output logic                    cpu_rsp_valid,
    output dcache_pkg::cpu_rsp_t    cpu_rsp,
    output logic                    mem_rd_valid,
    input  logic                    mem_rd_ready,
    output dcache_pkg::mem_rd_req_t mem_rd_req,
    input  logic                    mem_rd_data_valid,
    input  dcache_pkg::word_t       mem_rd_data,
    input  logic                    mem_rd_last,
    output logic                    mem_wr_valid,
    input  logic                    mem_wr_ready,
    output dcache_pkg::mem_wr_req_t mem_wr_req,
    output logic                    mem_wr_data_valid,
    input  logic                    mem_wr_data_ready,
    output dcache_pkg::word_t       mem_wr_data,
    output logic                    mem_wr_last,
    output logic                    mem_wr_resp_ready,
    input  logic                    mem_wr_resp_valid
);
    localparam int idx_w = $clog2(SETS);
    localparam int tag_w = 32 - idx_w - 4;

    dcache_pkg::cpu_req_t req_buf;
    logic [idx_w-1:0] index;
    logic [tag_w-1:0] tag;
    logic [tag_w-1:0] victim_tag;
    logic [1:0] word_sel;
    logic [3:0] byte_en;
    dcache_pkg::word_t wdata;
    dcache_pkg::word_t load_rdata;
    dcache_pkg::way_mask_t tag_way_we, data_way_we, touch_way, hit_way, victim_way;
    logic set_dirty, clr_dirty, fill, touch, victim_valid, victim_dirty;
    dcache_pkg::line_t fill_line, hit_line, wb_line;
    dcache_pkg::line_t [dcache_pkg::way_num-1:0] set_lines;

    // pick the hit line for loads and the victim line for write-back
    always_comb begin
        hit_line = '0;
        wb_line = '0;
        for (int w = 0; w < dcache_pkg::way_num; w++) begin
            if (hit_way[w]) begin
                hit_line = set_lines[w];
            end
            if (victim_way[w]) begin
                wb_line = set_lines[w];
            end
        end
    end

    // stores answer with zero
    assign cpu_rsp.rdata = req_buf.store ? '0 : load_rdata;

    dcache_ctrl #(.SETS(SETS)) i_ctrl (
        .clk(clk), .arst_n(arst_n),
        .cpu_req_valid(cpu_req_valid), .cpu_req_ready(cpu_req_ready),
        .cpu_req(cpu_req), .cpu_rsp_valid(cpu_rsp_valid), .req_buf(req_buf),
        .mem_rd_valid(mem_rd_valid), .mem_rd_ready(mem_rd_ready), .mem_rd_req(mem_rd_req),
        .mem_rd_data_valid(mem_rd_data_valid), .mem_rd_data(mem_rd_data),
        .mem_rd_last(mem_rd_last),
        .mem_wr_valid(mem_wr_valid), .mem_wr_ready(mem_wr_ready), .mem_wr_req(mem_wr_req),
        .mem_wr_data_valid(mem_wr_data_valid), .mem_wr_data_ready(mem_wr_data_ready),
        .mem_wr_data(mem_wr_data), .mem_wr_last(mem_wr_last),
        .mem_wr_resp_ready(mem_wr_resp_ready), .mem_wr_resp_valid(mem_wr_resp_valid),
        .index(index), .tag(tag), .word_sel(word_sel), .byte_en(byte_en), .wdata(wdata),
        .tag_way_we(tag_way_we), .set_dirty(set_dirty), .clr_dirty(clr_dirty),
        .data_way_we(data_way_we), .fill(fill), .fill_line(fill_line),
        .touch(touch), .touch_way(touch_way), .hit_way(hit_way), .victim_way(victim_way),
        .victim_tag(victim_tag), .victim_valid(victim_valid), .victim_dirty(victim_dirty),
        .wb_line(wb_line)
    );

    dcache_tag_array #(.SETS(SETS)) i_tag_array (
        .clk(clk), .arst_n(arst_n), .index(index), .tag(tag), .way_we(tag_way_we),
        .set_dirty(set_dirty), .clr_dirty(clr_dirty), .victim_way(victim_way),
        .hit_way(hit_way), .victim_tag(victim_tag), .victim_valid(victim_valid),
        .victim_dirty(victim_dirty)
    );

    dcache_data_array #(.SETS(SETS)) i_data_array (
        .clk(clk), .index(index), .word_sel(word_sel), .way_we(data_way_we),
        .byte_en(byte_en), .wdata(wdata), .fill(fill), .fill_line(fill_line),
        .set_lines(set_lines)
    );

    dcache_plru #(.SETS(SETS)) i_plru (
        .clk(clk), .arst_n(arst_n), .index(index), .touch(touch),
        .touch_way(touch_way), .victim_way(victim_way)
    );

    dcache_load_align i_load_align (
        .line(hit_line), .word_sel(word_sel), .byte_off(req_buf.addr[1:0]),
        .size(req_buf.size), .signed_ext(req_buf.signed_ext), .rdata(load_rdata)
    );

endmodule

// ==== dcache_sva.sv ====
module dcache_sva (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    cpu_req_ready,
    input logic                    cpu_rsp_valid,
    input logic                    mem_rd_valid,
    input logic                    mem_rd_ready,
    input dcache_pkg::mem_rd_req_t mem_rd_req,
    input logic                    mem_wr_valid
);
    // cache comes out of reset able to take a request
    ready_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> cpu_req_ready)
        else $error("cpu_req_ready low in the first cycle after reset");

    rd_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rd_valid && !mem_rd_ready |=> $stable(mem_rd_req))
        else $error("mem_rd_req changed while waiting for mem_rd_ready");

    // blocking cache, one response per request
    rsp_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_rsp_valid |=> !cpu_rsp_valid)
        else $error("cpu_rsp_valid high in two consecutive cycles");

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_rd_valid && mem_wr_valid))
        else $error("mem_rd_valid and mem_wr_valid high together");

endmodule

bind dcache dcache_sva i_sva (
    .clk(clk), .arst_n(arst_n), .cpu_req_ready(cpu_req_ready),
    .cpu_rsp_valid(cpu_rsp_valid), .mem_rd_valid(mem_rd_valid),
    .mem_rd_ready(mem_rd_ready), .mem_rd_req(mem_rd_req), .mem_wr_valid(mem_wr_valid)
);

// ==== dcache_tb.sv ====
module dcache_tb;

    localparam int mem_words = 2048;
    localparam int timeout_cycles = 1000;
    localparam logic [31:0] seed = 32'h4e9663a2;

    typedef logic [31:0] mem_t [mem_words];

    logic clk;
    logic arst_n;
    logic cpu_req_valid;
    logic cpu_req_ready;
    dcache_pkg::cpu_req_t cpu_req;
    logic cpu_rsp_valid;
    dcache_pkg::cpu_rsp_t cpu_rsp;
    logic mem_rd_valid, mem_rd_ready, mem_rd_data_valid, mem_rd_last;
    dcache_pkg::mem_rd_req_t mem_rd_req;
    dcache_pkg::word_t mem_rd_data, mem_wr_data;
    logic mem_wr_valid, mem_wr_ready, mem_wr_data_valid, mem_wr_data_ready, mem_wr_last;
    logic mem_wr_resp_ready, mem_wr_resp_valid;
    dcache_pkg::mem_wr_req_t mem_wr_req;

    mem_t mem;
    mem_t shadow;
    bit wb_seen [mem_words/4];
    int refill_count;
    int cycle = 0;
    int accept_cycle;
    int rsp_cycle;
    logic [31:0] exp_q [$];
    string name_q [$];

    dcache #(.SETS(64)) i_dut (
        .clk(clk), .arst_n(arst_n),
        .cpu_req_valid(cpu_req_valid), .cpu_req_ready(cpu_req_ready), .cpu_req(cpu_req),
        .cpu_rsp_valid(cpu_rsp_valid), .cpu_rsp(cpu_rsp),
        .mem_rd_valid(mem_rd_valid), .mem_rd_ready(mem_rd_ready), .mem_rd_req(mem_rd_req),
        .mem_rd_data_valid(mem_rd_data_valid), .mem_rd_data(mem_rd_data),
        .mem_rd_last(mem_rd_last),
        .mem_wr_valid(mem_wr_valid), .mem_wr_ready(mem_wr_ready), .mem_wr_req(mem_wr_req),
        .mem_wr_data_valid(mem_wr_data_valid), .mem_wr_data_ready(mem_wr_data_ready),
        .mem_wr_data(mem_wr_data), .mem_wr_last(mem_wr_last),
        .mem_wr_resp_ready(mem_wr_resp_ready), .mem_wr_resp_valid(mem_wr_resp_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // distinct value for every word address
    function automatic logic [31:0] fill_word(input int i);
        return (32'(i) * 32'h9e3779b1) ^ {16'(i), ~16'(i)};
    endfunction

    function automatic int byte_count(input dcache_pkg::access_size_e size);
        case (size)
            dcache_pkg::size_byte: return 1;
            dcache_pkg::size_half: return 2;
            default: return 4;
        endcase
    endfunction

    // little endian, bytes gathered one at a time
    function automatic logic [31:0] ref_load(input mem_t sm, input logic [31:0] addr,
                                             input dcache_pkg::access_size_e size,
                                             input logic sgn);
        logic [31:0] ba;
        logic [31:0] v;
        int n;
        n = byte_count(size);
        v = '0;
        for (int i = 0; i < n; i++) begin
            ba = addr + 32'(i);
            v[8*i +: 8] = sm[ba[12:2]][8*int'(ba[1:0]) +: 8];
        end
        if (sgn && n < 4 && v[8*n-1]) begin
            v = v | (32'hffffffff << (8 * n));
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %08h actual %08h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1, "wait expired");
    endtask

    task automatic shadow_store(input logic [31:0] addr, input dcache_pkg::access_size_e size,
                                input logic [31:0] wdata);
        logic [31:0] ba;
        for (int i = 0; i < byte_count(size); i++) begin
            ba = addr + 32'(i);
            shadow[ba[12:2]][8*int'(ba[1:0]) +: 8] = wdata[8*i +: 8];
        end
    endtask

    // one request, returns once the compare process has taken its response
    task automatic access(input logic store, input logic [31:0] addr,
                          input dcache_pkg::access_size_e size, input logic sgn,
                          input logic [31:0] wdata, input string name);
        int waited;
        logic accepted;
        if (store) begin
            shadow_store(addr, size, wdata);
            exp_q.push_back(32'h0);
        end else begin
            exp_q.push_back(ref_load(shadow, addr, size, sgn));
        end
        name_q.push_back(name);
        @(negedge clk);
        cpu_req_valid = 1'b1;
        cpu_req.store = store;
        cpu_req.addr = addr;
        cpu_req.wdata = wdata;
        cpu_req.size = size;
        cpu_req.signed_ext = sgn;
        cpu_req.spare = '0;
        waited = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            if (cpu_req_ready) begin
                accepted = 1'b1;
                accept_cycle = cycle;
            end else begin
                waited++;
                if (waited > timeout_cycles) report_timeout("cpu_req_ready");
            end
        end
        @(negedge clk);
        cpu_req_valid = 1'b0;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > timeout_cycles) report_timeout("the compare process to take a response");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // burst memory with random ready and data gaps
    initial begin : mem_model
        logic [31:0] rd_addr;
        logic [31:0] wr_addr;
        logic [31:0] r;
        int rd_beat;
        int wr_beat;
        logic rd_busy;
        logic wr_done;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = fill_word(i);
        end
        mem_rd_ready = 1'b0;
        mem_rd_data_valid = 1'b0;
        mem_rd_data = '0;
        mem_rd_last = 1'b0;
        mem_wr_ready = 1'b0;
        mem_wr_data_ready = 1'b0;
        mem_wr_resp_valid = 1'b0;
        refill_count = 0;
        rd_addr = '0;
        wr_addr = '0;
        rd_beat = 0;
        wr_beat = 0;
        rd_busy = 1'b0;
        wr_done = 1'b0;
        r = seed;
        forever begin
            @(posedge clk);
            if (mem_rd_valid && mem_rd_ready) begin
                rd_busy = 1'b1;
                rd_addr = mem_rd_req.addr;
                rd_beat = 0;
                refill_count++;
            end else if (mem_rd_data_valid) begin
                rd_beat++;
                if (mem_rd_last) rd_busy = 1'b0;
            end
            if (mem_wr_valid && mem_wr_ready) begin
                wr_addr = mem_wr_req.addr;
                wr_beat = 0;
                wb_seen[wr_addr[12:4]] = 1'b1;
            end
            if (mem_wr_data_valid && mem_wr_data_ready) begin
                check("write-back last flag", 32'(wr_beat == 3), 32'(mem_wr_last));
                mem[{wr_addr[12:4], wr_beat[1:0]}] = mem_wr_data;
                wr_beat++;
                if (wr_beat == 4) wr_done = 1'b1;
            end
            if (mem_wr_resp_valid && mem_wr_resp_ready) wr_done = 1'b0;
            @(negedge clk);
            r = xorshift32(r);
            mem_rd_ready = r[0] | r[1];
            mem_wr_ready = r[2] | r[3];
            mem_wr_data_ready = r[4] | r[5];
            mem_rd_data_valid = rd_busy && (r[6] | r[7]);
            mem_rd_data = mem[{rd_addr[12:4], rd_beat[1:0]}];
            mem_rd_last = (rd_beat == 3);
            // response holds until the cache takes it
            if (!wr_done) begin
                mem_wr_resp_valid = 1'b0;
            end else if (!mem_wr_resp_valid) begin
                mem_wr_resp_valid = r[8];
            end
        end
    end

    initial begin : compare
        int waited;
        logic got;
        forever begin
            waited = 0;
            while (exp_q.size() == 0) begin
                @(posedge clk);
                if (cpu_rsp_valid && exp_q.size() == 0) begin
                    $display("cpu_rsp_valid rose with no request outstanding");
                    $display("TEST FAILED");
                    $fatal(1, "stray response");
                end
                waited++;
                if (waited > timeout_cycles) report_timeout("the next request");
            end
            waited = 0;
            got = 1'b0;
            while (!got) begin
                @(posedge clk);
                if (cpu_rsp_valid) begin
                    got = 1'b1;
                end else begin
                    waited++;
                    if (waited > timeout_cycles) report_timeout("cpu_rsp_valid");
                end
            end
            rsp_cycle = cycle;
            check(name_q.pop_front(), exp_q.pop_front(), cpu_rsp.rdata);
        end
    end

    initial begin : stimulus
        logic [31:0] rng;
        logic [31:0] a;
        logic [31:0] wd;
        dcache_pkg::access_size_e sz;
        int n0;
        int idx;
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = fill_word(i);
        end
        arst_n = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req = '0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        // cold line, then a second word of it
        n0 = refill_count;
        access(1'b0, 32'h40, dcache_pkg::size_word, 1'b0, '0, "cold load");
        check("refills after cold load", 32'(n0 + 1), 32'(refill_count));
        access(1'b0, 32'h48, dcache_pkg::size_word, 1'b0, '0, "warm load");
        check("refills after warm load", 32'(n0 + 1), 32'(refill_count));

        // partial stores, then every load width and offset in the line
        access(1'b1, 32'h41, dcache_pkg::size_byte, 1'b0, 32'h85, "byte store");
        access(1'b1, 32'h46, dcache_pkg::size_half, 1'b0, 32'h9abc, "half store");
        access(1'b1, 32'h4c, dcache_pkg::size_word, 1'b0, 32'h87f4_2301, "word store");
        for (int off = 0; off < 16; off++) begin
            for (int s = 0; s < 2; s++) begin
                a = 32'h40 + 32'(off);
                access(1'b0, a, dcache_pkg::size_byte, s[0], '0, "byte load");
                if (off % 2 == 0) begin
                    access(1'b0, a, dcache_pkg::size_half, s[0], '0, "half load");
                end
                if (off % 4 == 0) begin
                    access(1'b0, a, dcache_pkg::size_word, s[0], '0, "word load");
                end
            end
        end

        access(1'b0, 32'h44, dcache_pkg::size_word, 1'b0, '0, "hit latency load");
        check("hit response cycle", 32'd1, 32'(rsp_cycle - accept_cycle));

        // five lines share set 9 but only four ways exist
        for (int k = 0; k < 5; k++) begin
            a = 32'h90 + 32'(k) * 32'h400;
            access(1'b1, a, dcache_pkg::size_word, 1'b0, 32'h3c00_0000 + 32'(k), "set store");
            access(1'b1, a + 32'h9, dcache_pkg::size_byte, 1'b0, 32'ha0 + 32'(k), "set store");
        end
        check("oldest line written back", 32'd1, 32'(wb_seen[9]));
        for (int k = 0; k < 5; k++) begin
            for (int w = 0; w < 4; w++) begin
                a = 32'h90 + 32'(k) * 32'h400 + 32'(4 * w);
                access(1'b0, a, dcache_pkg::size_word, 1'b0, '0, "set reload");
            end
        end
        for (int k = 0; k < 5; k++) begin
            idx = 9 + 64 * k;
            if (wb_seen[idx]) begin
                for (int w = 0; w < 4; w++) begin
                    check("written-back word", shadow[4*idx + w], mem[4*idx + w]);
                end
            end
        end

        // random traffic over two sets and six tags
        rng = seed;
        for (int i = 0; i < 400; i++) begin
            rng = xorshift32(rng);
            case (rng[2:1])
                2'd0: sz = dcache_pkg::size_byte;
                2'd1: sz = dcache_pkg::size_half;
                default: sz = dcache_pkg::size_word;
            endcase
            a = 32'(int'(rng[10:8]) % 6) * 32'h400 + (rng[11] ? 32'h20 : 32'h30)
                + 32'(rng[15:12]);
            if (sz == dcache_pkg::size_half) begin
                a[0] = 1'b0;
            end
            if (sz == dcache_pkg::size_word) begin
                a[1:0] = 2'b00;
            end
            wd = xorshift32(rng);
            access(rng[0], a, sz, rng[16], wd, $sformatf("random access %0d", i));
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== dcache.f ====
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_plru.sv
dcache_load_align.sv
dcache_ctrl.sv
dcache.sv
dcache_sva.sv
dcache_tb.sv

// ==== Makefile ====
TOP := dcache_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f dcache.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
